//--- build.f
design/icache_pkg.sv
design/fetch_cache.sv
design/refill_adapter.sv
design/wb_read_master.sv
design/icache_top.sv
tests/wb_mem_model.sv
tests/icache_properties.sv
tests/tb_icache_top.sv

//--- design/fetch_cache.sv
/*
 * Direct-mapped instruction cache core:
 * valid, tag and data arrays, tag compare, flush,
 * miss request control and the fetch response register
 */

`timescale 1ns/1ps

module fetch_cache import icache_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       flush_i,
  input  logic       fetch_valid_i,
  input  fetch_req_t fetch_req_i,
  output logic       fetch_ready_o,
  output logic       rsp_valid_o,
  output fetch_rsp_t rsp_o,
  output logic       miss_o,
  output logic       miss_valid_o,
  output miss_req_t  miss_req_o,
  input  logic       fill_valid_i,
  input  fill_rtrn_t fill_rtrn_i
);

  cache_state_e state_q;
  fetch_req_t   req_q;
  fetch_rsp_t   rsp_q;
  logic         rsp_valid_q;
  logic         miss_q;

  // Storage arrays
  logic [NUM_LINES-1:0]              valid_q;
  logic [TAG_W-1:0]                  tag_q  [NUM_LINES];
  logic [LINE_WORDS-1:0][WORD_W-1:0] data_q [NUM_LINES];

  logic [OFFSET_W-1:0] req_off;
  logic [INDEX_W-1:0]  req_idx;
  logic [TAG_W-1:0]    req_tag;
  logic                req_nc;
  logic                hit;
  logic                accept;
  logic                fill_wr;

  // Fields of the registered fetch address
  assign req_off = req_q.addr[BYTE_W +: OFFSET_W];
  assign req_idx = req_q.addr[BYTE_W+OFFSET_W +: INDEX_W];
  assign req_tag = req_q.addr[ADDR_W-1 -: TAG_W];
  assign req_nc  = req_q.addr[NC_BIT];

  // Uncached addresses never hit
  assign hit = valid_q[req_idx] & (tag_q[req_idx] == req_tag) & ~req_nc;

  // Flush has priority over a new fetch in IDLE
  assign fetch_ready_o = (state_q == CS_IDLE) & ~flush_i;
  assign accept        = fetch_valid_i & fetch_ready_o;

  // Only cached refills land in the arrays
  assign fill_wr = (state_q == CS_MISS_WAIT) & fill_valid_i & ~fill_rtrn_i.nc;

  // One-cycle refill request out of MISS_REQ
  assign miss_valid_o = (state_q == CS_MISS_REQ);

  always_comb begin
    miss_req_o.nc = req_nc;
    if (req_nc) begin
      // Single word at its exact address
      miss_req_o.paddr = {req_q.addr[ADDR_W-1:BYTE_W], {BYTE_W{1'b0}}};
    end else begin
      // Whole line, aligned to word 0
      miss_req_o.paddr = {req_q.addr[ADDR_W-1:BYTE_W+OFFSET_W], {(BYTE_W+OFFSET_W){1'b0}}};
    end
  end

  // Control state and valid bits
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q     <= CS_IDLE;
      valid_q     <= '0;
      rsp_valid_q <= 1'b0;
      miss_q      <= 1'b0;
    end else begin
      rsp_valid_q <= 1'b0;
      miss_q      <= 1'b0;
      case (state_q)
        CS_IDLE: begin
          if (flush_i) begin
            valid_q <= '0;
          end else if (accept) begin
            state_q <= CS_LOOKUP;
          end
        end
        CS_LOOKUP: begin
          if (hit) begin
            rsp_valid_q <= 1'b1;
            state_q     <= CS_IDLE;
          end else begin
            // Miss counted once per lookup
            miss_q  <= 1'b1;
            state_q <= CS_MISS_REQ;
          end
        end
        CS_MISS_REQ: begin
          state_q <= CS_MISS_WAIT;
        end
        CS_MISS_WAIT: begin
          if (fill_valid_i) begin
            rsp_valid_q <= 1'b1;
            state_q     <= CS_IDLE;
          end
          if (fill_wr) begin
            valid_q[req_idx] <= 1'b1;
          end
        end
        default: state_q <= CS_IDLE;
      endcase
    end
  end

  // Request, arrays and response word
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= fetch_req_i;
    end
    if (fill_wr) begin
      tag_q[req_idx]  <= req_tag;
      data_q[req_idx] <= fill_rtrn_i.data;
    end
    if (state_q == CS_LOOKUP) begin
      rsp_q.data <= data_q[req_idx][req_off];
    end else if (state_q == CS_MISS_WAIT && fill_valid_i) begin
      // Uncached word sits at offset 0 of the fill
      rsp_q.data <= fill_rtrn_i.nc ? fill_rtrn_i.data[0] : fill_rtrn_i.data[req_off];
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;
  assign miss_o      = miss_q;

endmodule

//--- design/icache_pkg.sv
/*
 * Shared definitions of the instruction-fetch subsystem:
 * cache geometry and address field widths, fetch, refill and
 * Wishbone payload structs, and the FSM state encodings
 */

package icache_pkg;

  // Cache geometry
  localparam int LINE_WORDS = 4;
  localparam int NUM_LINES  = 16;
  localparam int WORD_W     = 32;
  localparam int ADDR_W     = 32;

  // Byte address fields: tag | index | word offset | byte
  localparam int BYTE_W   = 2;
  localparam int OFFSET_W = $clog2(LINE_WORDS);
  localparam int INDEX_W  = $clog2(NUM_LINES);
  localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W - BYTE_W;

  // Top address bit selects the uncached region
  localparam int NC_BIT = ADDR_W - 1;

  // Width of the refill beat count (up to LINE_WORDS)
  localparam int BEATS_W = 3;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
  } fetch_req_t;

  typedef struct packed {
    logic [WORD_W-1:0] data;
  } fetch_rsp_t;

  // Line address, or exact word address when uncached
  typedef struct packed {
    logic [ADDR_W-1:0] paddr;
    logic              nc;
  } miss_req_t;

  typedef struct packed {
    logic [LINE_WORDS-1:0][WORD_W-1:0] data;
    logic                              nc;
  } fill_rtrn_t;

  typedef struct packed {
    logic [WORD_W-1:0] data;
    logic              last;
  } bus_beat_t;

  typedef struct packed {
    logic                cyc;
    logic                stb;
    logic                we;
    logic [ADDR_W-1:0]   adr;
    logic [WORD_W/8-1:0] sel;
  } wb_m2s_t;

  typedef struct packed {
    logic              ack;
    logic [WORD_W-1:0] dat;
  } wb_s2m_t;

  typedef enum logic [1:0] {
    CS_IDLE,
    CS_LOOKUP,
    CS_MISS_REQ,
    CS_MISS_WAIT
  } cache_state_e;

  typedef enum logic [1:0] {
    WB_IDLE,
    WB_BUS,
    WB_DONE
  } wb_state_e;

endpackage

//--- design/icache_top.sv
/*
 * Instruction-fetch subsystem top level:
 * fetch cache, refill adapter and Wishbone read master
 */

`timescale 1ns/1ps

module icache_top import icache_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       flush_i,
  input  logic       fetch_valid_i,
  input  fetch_req_t fetch_req_i,
  output logic       fetch_ready_o,
  output logic       rsp_valid_o,
  output fetch_rsp_t rsp_o,
  output logic       miss_o,
  output wb_m2s_t    wb_m2s_o,
  input  wb_s2m_t    wb_s2m_i
);

  // Cache to adapter
  logic       miss_valid;
  miss_req_t  miss_req;
  logic       fill_valid;
  fill_rtrn_t fill_rtrn;

  // Adapter to bus master
  logic               rd_req;
  logic [ADDR_W-1:0]  rd_addr;
  logic [BEATS_W-1:0] rd_beats;
  logic               rd_gnt;
  logic               beat_valid;
  bus_beat_t          bus_beat;

  fetch_cache u_fetch_cache (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .flush_i       (flush_i),
    .fetch_valid_i (fetch_valid_i),
    .fetch_req_i   (fetch_req_i),
    .fetch_ready_o (fetch_ready_o),
    .rsp_valid_o   (rsp_valid_o),
    .rsp_o         (rsp_o),
    .miss_o        (miss_o),
    .miss_valid_o  (miss_valid),
    .miss_req_o    (miss_req),
    .fill_valid_i  (fill_valid),
    .fill_rtrn_i   (fill_rtrn)
  );

  refill_adapter u_refill_adapter (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .miss_valid_i (miss_valid),
    .miss_req_i   (miss_req),
    .fill_valid_o (fill_valid),
    .fill_rtrn_o  (fill_rtrn),
    .rd_req_o     (rd_req),
    .rd_addr_o    (rd_addr),
    .rd_beats_o   (rd_beats),
    .rd_gnt_i     (rd_gnt),
    .beat_valid_i (beat_valid),
    .bus_beat_i   (bus_beat)
  );

  wb_read_master u_wb_read_master (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .rd_req_i     (rd_req),
    .rd_addr_i    (rd_addr),
    .rd_beats_i   (rd_beats),
    .rd_gnt_o     (rd_gnt),
    .beat_valid_o (beat_valid),
    .bus_beat_o   (bus_beat),
    .wb_m2s_o     (wb_m2s_o),
    .wb_s2m_i     (wb_s2m_i)
  );

endmodule

//--- design/refill_adapter.sv
/*
 * Refill adapter between the cache and the bus master:
 * holds a refill request until granted and assembles
 * returned bus beats into a cache line
 */

`timescale 1ns/1ps

module refill_adapter import icache_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               miss_valid_i,
  input  miss_req_t          miss_req_i,
  output logic               fill_valid_o,
  output fill_rtrn_t         fill_rtrn_o,
  output logic               rd_req_o,
  output logic [ADDR_W-1:0]  rd_addr_o,
  output logic [BEATS_W-1:0] rd_beats_o,
  input  logic               rd_gnt_i,
  input  logic               beat_valid_i,
  input  bus_beat_t          bus_beat_i
);

  logic      pending_d, pending_q;
  miss_req_t req_d, req_q;
  logic      first_d, first_q;

  logic [LINE_WORDS-1:0][WORD_W-1:0] shift_d, shift_q;

  // Request stays up until the master grants it
  assign pending_d = ~rd_gnt_i & (miss_valid_i | pending_q);

  // Capture a fresh request, otherwise hold the stored one
  assign req_d = miss_valid_i ? miss_req_i : req_q;

  // New or pending request
  assign rd_req_o  = miss_valid_i | pending_q;
  assign rd_addr_o = req_d.paddr;

  // Full line on a miss, one word when uncached
  assign rd_beats_o = req_d.nc ? BEATS_W'(1) : BEATS_W'(LINE_WORDS);

  // Line is handed over together with the last beat
  assign fill_valid_o     = beat_valid_i & bus_beat_i.last;
  assign fill_rtrn_o.data = shift_d;
  assign fill_rtrn_o.nc   = req_q.nc;

  // Beats enter at the top word and move down
  always_comb begin
    first_d = first_q;
    shift_d = shift_q;
    if (beat_valid_i) begin
      // Next beat after a last one starts a new transfer
      first_d = bus_beat_i.last;
      shift_d = {bus_beat_i.data, shift_q[LINE_WORDS-1:1]};
      // A single-beat read must end up at offset 0
      if (first_q) begin
        shift_d[0] = bus_beat_i.data;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pending_q <= 1'b0;
      first_q   <= 1'b1;
    end else begin
      pending_q <= pending_d;
      first_q   <= first_d;
    end
  end

  // Request copy and line buffer
  always_ff @(posedge clk_i) begin
    req_q   <= req_d;
    shift_q <= shift_d;
  end

endmodule

//--- design/wb_read_master.sv
/*
 * Wishbone classic read master:
 * turns a granted refill into a run of single reads,
 * stepping the address and flagging the final beat
 */

`timescale 1ns/1ps

module wb_read_master import icache_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               rd_req_i,
  input  logic [ADDR_W-1:0]  rd_addr_i,
  input  logic [BEATS_W-1:0] rd_beats_i,
  output logic               rd_gnt_o,
  output logic               beat_valid_o,
  output bus_beat_t          bus_beat_o,
  output wb_m2s_t            wb_m2s_o,
  input  wb_s2m_t            wb_s2m_i
);

  wb_state_e          state_q;
  logic [BEATS_W-1:0] remaining_q;
  logic [ADDR_W-1:0]  adr_q;
  logic               cyc_q;
  logic               stb_q;
  logic               beat_valid_q;
  bus_beat_t          beat_q;
  logic               ack;
  logic               last_ack;

  // Grant only while no transfer is running
  assign rd_gnt_o = rd_req_i & (state_q == WB_IDLE);

  // Ack counts only against an active strobe
  assign ack      = wb_s2m_i.ack & cyc_q & stb_q;
  assign last_ack = ack & (remaining_q == BEATS_W'(1));

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q      <= WB_IDLE;
      remaining_q  <= '0;
      cyc_q        <= 1'b0;
      stb_q        <= 1'b0;
      beat_valid_q <= 1'b0;
    end else begin
      beat_valid_q <= ack;
      case (state_q)
        WB_IDLE: begin
          if (rd_gnt_o) begin
            cyc_q       <= 1'b1;
            stb_q       <= 1'b1;
            remaining_q <= rd_beats_i;
            state_q     <= WB_BUS;
          end
        end
        WB_BUS: begin
          if (ack) begin
            // Strobe gap of one cycle after each ack
            stb_q       <= 1'b0;
            remaining_q <= remaining_q - BEATS_W'(1);
            if (last_ack) begin
              cyc_q   <= 1'b0;
              state_q <= WB_DONE;
            end
          end else if (!stb_q) begin
            stb_q <= 1'b1;
          end
        end
        WB_DONE: state_q <= WB_IDLE;
        default: state_q <= WB_IDLE;
      endcase
    end
  end

  // Address stepping and returned data
  always_ff @(posedge clk_i) begin
    if (rd_gnt_o) begin
      adr_q <= rd_addr_i;
    end else if (ack && !last_ack) begin
      adr_q <= adr_q + ADDR_W'(4);
    end
    if (ack) begin
      beat_q.data <= wb_s2m_i.dat;
      beat_q.last <= last_ack;
    end
  end

  assign beat_valid_o = beat_valid_q;
  assign bus_beat_o   = beat_q;

  // Read-only master with all byte lanes
  assign wb_m2s_o.cyc = cyc_q;
  assign wb_m2s_o.stb = stb_q;
  assign wb_m2s_o.we  = 1'b0;
  assign wb_m2s_o.adr = adr_q;
  assign wb_m2s_o.sel = '1;

endmodule

//--- run.sh
#!/bin/sh
# Build and run the instruction cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_icache_top -f build.f -o sim_icache
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

# Keep running after an assertion error so the testbench can report it
./obj_dir/sim_icache +verilator+error+limit+100
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation ended with status $status"
fi
exit $status

//--- tests/icache_properties.sv
/*
 * Concurrent checks bound into the fetch subsystem top:
 * Wishbone classic handshake rules and refill return order
 */

`timescale 1ns/1ps

module icache_properties import icache_pkg::*; (
  input logic    clk_i,
  input logic    rst_n_i,
  input wb_m2s_t wb_m2s_i,
  input wb_s2m_t wb_s2m_i,
  input logic    beat_valid_i,
  input logic    miss_valid_i,
  input logic    fill_valid_i
);

  int   fail_cnt = 0;
  logic refill_open_q;

  // Open from the miss request until the line comes back
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      refill_open_q <= 1'b0;
    end else if (miss_valid_i) begin
      refill_open_q <= 1'b1;
    end else if (fill_valid_i) begin
      refill_open_q <= 1'b0;
    end
  end

  stb_in_cyc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_m2s_i.stb |-> wb_m2s_i.cyc)
    else begin fail_cnt++; $error("stb high outside a bus cycle"); end

  // Address held until the slave acks
  adr_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (wb_m2s_i.stb && !wb_s2m_i.ack) |=> (wb_m2s_i.stb && $stable(wb_m2s_i.adr)))
    else begin fail_cnt++; $error("stb or adr changed before ack"); end

  ack_after_stb: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_s2m_i.ack |-> (wb_m2s_i.cyc && wb_m2s_i.stb))
    else begin fail_cnt++; $error("ack without an active strobe"); end

  beat_after_ack: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    beat_valid_i |-> $past(wb_s2m_i.ack && wb_m2s_i.stb))
    else begin fail_cnt++; $error("beat_valid without a registered ack"); end

  fill_when_open: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    fill_valid_i |-> refill_open_q)
    else begin fail_cnt++; $error("fill_valid with no refill outstanding"); end

endmodule

bind icache_top icache_properties u_props (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .wb_m2s_i     (wb_m2s_o),
  .wb_s2m_i     (wb_s2m_i),
  .beat_valid_i (beat_valid),
  .miss_valid_i (miss_valid),
  .fill_valid_i (fill_valid)
);

//--- tests/tb_icache_top.sv
/*
 * Testbench for the instruction-fetch subsystem:
 * clock and reset, directed and random fetches,
 * reference word function, response checker and end of run
 */

`timescale 1ns/1ps

module tb_icache_top import icache_pkg::*; ();

  logic       clk_i = 1'b0;
  logic       rst_n_i;
  logic       flush_i;
  logic       fetch_valid_i;
  fetch_req_t fetch_req_i;
  logic       fetch_ready_o;
  logic       rsp_valid_o;
  fetch_rsp_t rsp_o;
  logic       miss_o;
  wb_m2s_t    wb_m2s;
  wb_s2m_t    wb_s2m;

  // Expected words in fetch order
  logic [WORD_W-1:0] exp_q [$];

  integer seed = 22;
  int     wait_limit = 500;
  int     cycle_cnt = 0;
  int     sent_cnt = 0;
  int     rsp_cnt = 0;
  int     miss_cnt = 0;
  int     ack_cnt = 0;
  int     bus_cnt = 0;
  int     accept_cyc = 0;
  int     rsp_cyc = 0;
  bit     cyc_seen = 1'b0;
  bit     in_flight = 1'b0;

  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

  icache_top DUT (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .flush_i       (flush_i),
    .fetch_valid_i (fetch_valid_i),
    .fetch_req_i   (fetch_req_i),
    .fetch_ready_o (fetch_ready_o),
    .rsp_valid_o   (rsp_valid_o),
    .rsp_o         (rsp_o),
    .miss_o        (miss_o),
    .wb_m2s_o      (wb_m2s),
    .wb_s2m_i      (wb_s2m)
  );

  wb_mem_model u_mem (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .wb_m2s_i (wb_m2s),
    .wb_s2m_o (wb_s2m)
  );

  // Memory word for a fetch address, byte bits ignored
  function automatic logic [WORD_W-1:0] ref_word(input logic [ADDR_W-1:0] addr);
    logic [ADDR_W-1:0] a;
    a = {addr[ADDR_W-1:2], 2'b00};
    return (a ^ 32'hA5A5_0000) + (a >> 2);
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("FAIL at time %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  // Mid-cycle sampling of responses and bus events
  always @(negedge clk_i) begin
    if (rst_n_i) begin
      // Ready stays low from acceptance until the response
      if (in_flight && fetch_ready_o && !rsp_valid_o) begin
        abort_run("fetch_ready_o rose while a fetch was in flight");
      end
      if (fetch_valid_i && fetch_ready_o) begin
        accept_cyc = cycle_cnt;
        in_flight  = 1'b1;
      end
      if (miss_o) begin
        miss_cnt++;
      end
      if (wb_m2s.cyc && !cyc_seen) begin
        bus_cnt++;
      end
      cyc_seen = wb_m2s.cyc;
      // Reads only, all byte lanes
      if (wb_m2s.stb) begin
        check_value("Wishbone we and sel", 32'({wb_m2s.we, wb_m2s.sel}), 32'h0F);
      end
      if (wb_m2s.stb && wb_s2m.ack) begin
        ack_cnt++;
      end
      if (rsp_valid_o) begin
        rsp_cyc   = cycle_cnt;
        in_flight = 1'b0;
        if (exp_q.size() == 0) begin
          abort_run("A fetch response arrived with no fetch pending");
        end else begin
          check_value("rsp_o", rsp_o.data, exp_q.pop_front());
          rsp_cnt++;
        end
      end
      if (DUT.u_props.fail_cnt != 0) begin
        abort_run("A bound Wishbone or refill assertion failed");
      end
    end
  end

  // One fetch, then wait for its response
  task automatic fetch_word(input logic [ADDR_W-1:0] addr);
    int n;
    n = 0;
    @(negedge clk_i);
    while (!fetch_ready_o) begin
      n++;
      if (n > wait_limit) abort_run("Timed out waiting for fetch_ready_o");
      @(negedge clk_i);
    end
    @(posedge clk_i);
    fetch_valid_i    <= 1'b1;
    fetch_req_i.addr <= addr;
    exp_q.push_back(ref_word(addr));
    sent_cnt++;
    @(posedge clk_i);
    fetch_valid_i <= 1'b0;
    n = 0;
    while (rsp_cnt < sent_cnt) begin
      n++;
      if (n > wait_limit) abort_run("Timed out waiting for a fetch response");
      @(posedge clk_i);
    end
  endtask

  // Fetch and check miss pulses, acks, bus cycles and hit latency
  task automatic fetch_check(input logic [ADDR_W-1:0] addr, input bit exp_miss,
                             input int exp_acks);
    int miss0;
    int ack0;
    int bus0;
    miss0 = miss_cnt;
    ack0  = ack_cnt;
    bus0  = bus_cnt;
    fetch_word(addr);
    check_value("miss_o pulses", 32'(miss_cnt - miss0), exp_miss ? 32'd1 : 32'd0);
    check_value("Wishbone acks", 32'(ack_cnt - ack0), 32'(exp_acks));
    check_value("bus cycles", 32'(bus_cnt - bus0), exp_miss ? 32'd1 : 32'd0);
    if (!exp_miss) begin
      check_value("hit latency", 32'(rsp_cyc - accept_cyc), 32'd2);
    end
  endtask

  task automatic flush_cache();
    @(posedge clk_i);
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] addr;
    rst_n_i       = 1'b0;
    flush_i       = 1'b0;
    fetch_valid_i = 1'b0;
    fetch_req_i   = '0;
    repeat (3) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    // ready, rsp_valid, miss, cyc, stb
    check_value("outputs after reset",
                32'({fetch_ready_o, rsp_valid_o, miss_o, wb_m2s.cyc, wb_m2s.stb}), 32'h10);

    // Line fill, then hits on the rest of the line
    fetch_check(32'h0000_1048, 1'b1, LINE_WORDS);
    fetch_check(32'h0000_1040, 1'b0, 0);
    fetch_check(32'h0000_1044, 1'b0, 0);
    fetch_check(32'h0000_104C, 1'b0, 0);

    // Uncached word at offset 2 is never kept
    fetch_check(32'h8000_2008, 1'b1, 1);
    fetch_check(32'h8000_2008, 1'b1, 1);

    // Same index, different tags
    fetch_check(32'h0000_3050, 1'b1, LINE_WORDS);
    fetch_check(32'h0000_7054, 1'b1, LINE_WORDS);
    fetch_check(32'h0000_3058, 1'b1, LINE_WORDS);
    fetch_check(32'h0000_705C, 1'b1, LINE_WORDS);

    // Flush drops a resident line
    fetch_check(32'h0000_1048, 1'b0, 0);
    flush_cache();
    fetch_check(32'h0000_1048, 1'b1, LINE_WORDS);

    // Small range, bit 9 of the draw picks the uncached region
    for (int i = 0; i < 200; i++) begin
      r    = $random(seed);
      addr = (r & 32'h0000_01FC) | (r[9] ? 32'h8000_0000 : 32'h0);
      fetch_word(addr);
    end

    // Fetch side ready and bus idle once the last response is in
    @(negedge clk_i);
    if (fetch_ready_o && !wb_m2s.cyc) begin
      $display("TEST OK");
      $finish;
    end else begin
      abort_run("The DUT did not return to idle at the end of the run");
    end
  end

endmodule

//--- tests/wb_mem_model.sv
/*
 * Wishbone classic read slave for the testbench:
 * random ack delay per access and address-derived read data
 */

`timescale 1ns/1ps

module wb_mem_model import icache_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  wb_m2s_t wb_m2s_i,
  output wb_s2m_t wb_s2m_o
);

  integer     seed = 22;
  logic       busy_q;
  logic [1:0] wait_q;

  // Byte address XOR a fixed pattern, plus the word index
  function automatic logic [WORD_W-1:0] word_at(input logic [ADDR_W-1:0] adr);
    return (adr ^ 32'hA5A5_0000) + (adr >> 2);
  endfunction

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      wb_s2m_o <= '0;
      busy_q   <= 1'b0;
      wait_q   <= 2'd0;
    end else if (wb_s2m_o.ack) begin
      // Ack lasts one cycle, master drops stb next
      wb_s2m_o.ack <= 1'b0;
      busy_q       <= 1'b0;
    end else if (wb_m2s_i.cyc && wb_m2s_i.stb) begin
      if (!busy_q) begin
        // New access, pick 0 to 3 wait cycles
        busy_q <= 1'b1;
        wait_q <= 2'($random(seed));
      end else if (wait_q != 2'd0) begin
        wait_q <= wait_q - 2'd1;
      end else begin
        wb_s2m_o.ack <= 1'b1;
        wb_s2m_o.dat <= word_at(wb_m2s_i.adr);
      end
    end
  end

endmodule
